// ==== design/ntm_arith_pkg.sv ====
// Data word width and type, modular add and subtract helpers
package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word format
  ////////////////////////////////////////////////////////////////////////////

  // Width of every operand, modulus, length and result
  localparam int DATA_SIZE = 32;

  // Plain unsigned data word
  typedef logic [DATA_SIZE-1:0] data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Modular arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // Modular sum of two words already reduced below the modulus
  // One extra bit keeps the carry so the compare sees the true sum
  function automatic data_t mod_add(data_t a, data_t b, data_t modulo);
    logic [DATA_SIZE:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    // Sum is below twice the modulus, one correction is enough
    if (sum >= {1'b0, modulo}) begin
      sum = sum - {1'b0, modulo};
    end
    return sum[DATA_SIZE-1:0];
  endfunction

  // Modular difference of two words already reduced below the modulus
  function automatic data_t mod_sub(data_t a, data_t b, data_t modulo);
    data_t diff;
    diff = a - b;
    // Borrow case, the wrapped word plus the modulus lands back in range
    if (a < b) begin
      diff = diff + modulo;
    end
    return diff;
  endfunction

endpackage

// ==== design/ntm_cmd_pkg.sv ====
// Opcode width, opcode type and command encodings
package ntm_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command codes
  ////////////////////////////////////////////////////////////////////////////

  // Width of the OPCODE field
  localparam int OPCODE_SIZE = 2;

  // Scalar commands
  // OP_ADD  single modular addition of A and B
  // OP_SUB  single modular subtraction, A minus B
  // OP_SUM  modular summation of LENGTH_IN streamed samples
  // Code 2'b11 is left unused and is illegal on START
  typedef enum logic [OPCODE_SIZE-1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_SUM = 2'b10
  } opcode_t;

endpackage

// ==== design/ntm_scalar_decode.sv ====
// Command decode with operand latching, busy flag and execute launch
module ntm_scalar_decode (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_cmd_pkg::opcode_t OPCODE,
  input  ntm_arith_pkg::data_t MODULO_IN,
  input  ntm_arith_pkg::data_t LENGTH_IN,
  input  ntm_arith_pkg::data_t DATA_A_IN,
  input  ntm_arith_pkg::data_t DATA_B_IN,
  input  logic                 result_done,
  output logic                 start_add,
  output logic                 sub_sel,
  output logic                 start_sum,
  output ntm_arith_pkg::data_t modulo_reg,
  output ntm_arith_pkg::data_t length_reg,
  output ntm_arith_pkg::data_t a_reg,
  output ntm_arith_pkg::data_t b_reg
);

  import ntm_cmd_pkg::*;

  // High from an accepted START until the result pulse comes back
  logic busy;
  // START taken this cycle
  logic accept;

  assign accept = START && !busy;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      start_add <= 1'b0;
      start_sum <= 1'b0;
    end else begin
      // One launch pulse per command, chosen by the opcode
      start_add <= accept && ((OPCODE == OP_ADD) || (OPCODE == OP_SUB));
      start_sum <= accept && (OPCODE == OP_SUM);
      // Busy set on accept, dropped by the result stage
      if (accept) begin
        busy <= 1'b1;
      end else if (result_done) begin
        busy <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////////////////////////////////////////

  // Held stable for the whole command, execute units read them directly
  always_ff @(posedge CLK) begin
    if (accept) begin
      modulo_reg <= MODULO_IN;
      length_reg <= LENGTH_IN;
      a_reg      <= DATA_A_IN;
      b_reg      <= DATA_B_IN;
      sub_sel    <= (OPCODE == OP_SUB);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // No new command until the previous READY has gone by
  a_start_idle : assert property (@(posedge CLK) disable iff (RST)
    START |-> !busy)
    else $error("START raised while a command is in flight");

  a_opcode_legal : assert property (@(posedge CLK) disable iff (RST)
    START |-> (OPCODE inside {OP_ADD, OP_SUB, OP_SUM}))
    else $error("illegal OPCODE on START");

  a_modulo_nonzero : assert property (@(posedge CLK) disable iff (RST)
    START |-> (MODULO_IN != '0))
    else $error("zero MODULO_IN on START");

  // Zero length would never finish the summation
  a_length_nonzero : assert property (@(posedge CLK) disable iff (RST)
    (START && (OPCODE == OP_SUM)) |-> (LENGTH_IN != '0))
    else $error("zero LENGTH_IN on summation START");

endmodule

// ==== design/ntm_scalar_adder.sv ====
// Registered single modular addition or subtraction
module ntm_scalar_adder (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start_add,
  input  logic                 sub_sel,
  input  ntm_arith_pkg::data_t modulo_reg,
  input  ntm_arith_pkg::data_t a_reg,
  input  ntm_arith_pkg::data_t b_reg,
  output logic                 add_done,
  output ntm_arith_pkg::data_t add_result
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Completion strobe
  ////////////////////////////////////////////////////////////////////////////

  // Fixed one cycle latency, done simply follows the launch
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      add_done <= 1'b0;
    end else begin
      add_done <= start_add;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  // Operands come straight from the decode registers
  // sub_sel picks A minus B, otherwise A plus B
  always_ff @(posedge CLK) begin
    if (start_add) begin
      if (sub_sel) begin
        add_result <= mod_sub(a_reg, b_reg, modulo_reg);
      end else begin
        add_result <= mod_add(a_reg, b_reg, modulo_reg);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Single correction step in the helpers needs reduced operands
  a_operands_reduced : assert property (@(posedge CLK) disable iff (RST)
    start_add |-> ((a_reg < modulo_reg) && (b_reg < modulo_reg)))
    else $error("adder operand not below modulus");

endmodule

// ==== design/ntm_scalar_summation_function.sv ====
// Streamed modular summation over a given number of samples
module ntm_scalar_summation_function (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start_sum,
  input  ntm_arith_pkg::data_t modulo_reg,
  input  ntm_arith_pkg::data_t length_reg,
  input  ntm_arith_pkg::data_t DATA_IN,
  input  logic                 DATA_IN_ENABLE,
  output logic                 sum_done,
  output ntm_arith_pkg::data_t sum_result
);

  import ntm_arith_pkg::*;

  // Two state FSM, low is idle, high is accumulate
  logic  accumulating;
  // Index of the next expected sample
  data_t index_loop;
  // Running modular sum
  data_t accumulator;
  // Accumulator with the current sample folded in
  data_t next_sum;
  // Current sample is the final one
  logic  last_sample;
  // Sample taken on this edge
  logic  take_sample;

  assign next_sum    = mod_add(DATA_IN, accumulator, modulo_reg);
  assign last_sample = (index_loop == (length_reg - data_t'(1)));
  assign take_sample = accumulating && DATA_IN_ENABLE;

  ////////////////////////////////////////////////////////////////////////////
  // FSM and sample counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      accumulating <= 1'b0;
      index_loop   <= '0;
      sum_done     <= 1'b0;
    end else begin
      sum_done <= 1'b0;
      if (!accumulating) begin
        // Idle, wait for the launch from decode
        if (start_sum) begin
          accumulating <= 1'b1;
          index_loop   <= '0;
        end
      end else if (DATA_IN_ENABLE) begin
        // Accumulate, one sample per enabled cycle
        if (last_sample) begin
          sum_done     <= 1'b1;
          accumulating <= 1'b0;
        end else begin
          index_loop <= index_loop + data_t'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator and result
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_sum) begin
      // Fresh sum for every command
      accumulator <= '0;
    end else if (take_sample) begin
      accumulator <= next_sum;
    end
    // Final value goes out on the same edge that takes the last sample
    if (take_sample && last_sample) begin
      sum_result <= next_sum;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Stream must be reduced against the modulus latched by decode
  a_sample_reduced : assert property (@(posedge CLK) disable iff (RST)
    take_sample |-> (DATA_IN < modulo_reg))
    else $error("DATA_IN sample not below modulus");

endmodule

// ==== design/ntm_scalar_result.sv ====
// Result merge, held output register and completion strobes
module ntm_scalar_result (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 add_done,
  input  ntm_arith_pkg::data_t add_result,
  input  logic                 sum_done,
  input  ntm_arith_pkg::data_t sum_result,
  output ntm_arith_pkg::data_t DATA_OUT,
  output logic                 DATA_OUT_ENABLE,
  output logic                 READY,
  output logic                 result_done
);

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // Only one execute unit completes at a time
  // DATA_OUT keeps the last result until the next completion
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= add_done || sum_done;
      if (add_done) begin
        DATA_OUT <= add_result;
      end else if (sum_done) begin
        DATA_OUT <= sum_result;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////////////////////

  // READY and the busy release to decode share the data strobe
  assign READY       = DATA_OUT_ENABLE;
  assign result_done = DATA_OUT_ENABLE;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Decode launches one unit per command, completions never collide
  a_single_completion : assert property (@(posedge CLK) disable iff (RST)
    !(add_done && sum_done))
    else $error("adder and summation completed in the same cycle");

endmodule

// ==== design/ntm_scalar_unit.sv ====
// Scalar arithmetic unit top level, decode, execute and result
module ntm_scalar_unit (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  ntm_cmd_pkg::opcode_t OPCODE,
  input  ntm_arith_pkg::data_t MODULO_IN,
  input  ntm_arith_pkg::data_t LENGTH_IN,
  input  ntm_arith_pkg::data_t DATA_A_IN,
  input  ntm_arith_pkg::data_t DATA_B_IN,
  input  ntm_arith_pkg::data_t DATA_IN,
  input  logic                 DATA_IN_ENABLE,
  output logic                 READY,
  output logic                 DATA_OUT_ENABLE,
  output ntm_arith_pkg::data_t DATA_OUT
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////////////

  // Latched command operands
  data_t modulo_reg;
  data_t length_reg;
  data_t a_reg;
  data_t b_reg;

  // Launch pulses and subtract select
  logic  start_add;
  logic  sub_sel;
  logic  start_sum;

  // Execute completions
  logic  add_done;
  data_t add_result;
  logic  sum_done;
  data_t sum_result;

  // Busy release back to decode
  logic  result_done;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_decode u_decode (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .OPCODE      (OPCODE),
    .MODULO_IN   (MODULO_IN),
    .LENGTH_IN   (LENGTH_IN),
    .DATA_A_IN   (DATA_A_IN),
    .DATA_B_IN   (DATA_B_IN),
    .result_done (result_done),
    .start_add   (start_add),
    .sub_sel     (sub_sel),
    .start_sum   (start_sum),
    .modulo_reg  (modulo_reg),
    .length_reg  (length_reg),
    .a_reg       (a_reg),
    .b_reg       (b_reg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  // Single add or subtract
  ntm_scalar_adder u_adder (
    .CLK        (CLK),
    .RST        (RST),
    .start_add  (start_add),
    .sub_sel    (sub_sel),
    .modulo_reg (modulo_reg),
    .a_reg      (a_reg),
    .b_reg      (b_reg),
    .add_done   (add_done),
    .add_result (add_result)
  );

  // Streamed summation
  ntm_scalar_summation_function u_summation (
    .CLK            (CLK),
    .RST            (RST),
    .start_sum      (start_sum),
    .modulo_reg     (modulo_reg),
    .length_reg     (length_reg),
    .DATA_IN        (DATA_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .sum_done       (sum_done),
    .sum_result     (sum_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_result u_result (
    .CLK             (CLK),
    .RST             (RST),
    .add_done        (add_done),
    .add_result      (add_result),
    .sum_done        (sum_done),
    .sum_result      (sum_result),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY),
    .result_done     (result_done)
  );

endmodule

// ==== bench/ntm_scalar_unit_tb.sv ====
// Testbench for the scalar unit with stimulus, reference model, checks and watchdog
module ntm_scalar_unit_tb;

  import ntm_arith_pkg::*;
  import ntm_cmd_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_CMDS     = 60;
  localparam int MAX_LEN      = 8;
  localparam int MAX_GAP      = 3;
  // Launch, ignored slot, gapped samples, result and idle gap
  localparam int WORST_CYCLES = 2 + MAX_LEN * (MAX_GAP + 1) + 5;
  localparam int TIMEOUT      = (RESET_CYCLES + (NUM_CMDS + 5) * WORST_CYCLES + 50) * CLK_PERIOD;

  logic    CLK;
  logic    RST;
  logic    START;
  opcode_t OPCODE;
  data_t   MODULO_IN;
  data_t   LENGTH_IN;
  data_t   DATA_A_IN;
  data_t   DATA_B_IN;
  data_t   DATA_IN;
  logic    DATA_IN_ENABLE;
  logic    READY;
  logic    DATA_OUT_ENABLE;
  data_t   DATA_OUT;

  // Reference model state
  data_t exp_q[$];
  data_t exp_head;
  data_t last_result;
  logic  in_flight;
  logic  sum_cmd;
  logic  started;
  // Marks the final enabled sample of a summation
  logic  last_en;

  ntm_scalar_unit uut (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped at the first failing check");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference arithmetic in 64 bits so nothing wraps before the remainder
  ////////////////////////////////////////////////////////////////////////////

  function automatic data_t expect_add(data_t a, data_t b, data_t m);
    return data_t'((64'(a) + 64'(b)) % 64'(m));
  endfunction

  function automatic data_t expect_sub(data_t a, data_t b, data_t m);
    return data_t'((64'(a) + 64'(m) - 64'(b)) % 64'(m));
  endfunction

  // Small moduli half the time so sums wrap often
  function automatic data_t pick_modulus();
    data_t m;
    m = ($urandom % 2) ? data_t'($urandom % 16) : data_t'($urandom);
    if (m == '0) begin
      m = data_t'(1);
    end
    return m;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Command drivers entered on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue(opcode_t op, data_t m, data_t len, data_t a, data_t b, data_t expv);
    START     = 1'b1;
    OPCODE    = op;
    MODULO_IN = m;
    LENGTH_IN = len;
    DATA_A_IN = a;
    DATA_B_IN = b;
    exp_q.push_back(expv);
    exp_head  = exp_q[0];
    in_flight = 1'b1;
    sum_cmd   = (op == OP_SUM);
    started   = 1'b1;
    @(negedge CLK);
    START     = 1'b0;
    // Scrambled so only the latched copies can give the right answer
    MODULO_IN = $urandom;
    DATA_A_IN = $urandom;
    DATA_B_IN = $urandom;
  endtask

  // Wait for the result strobe and retire the command one edge after its check
  task automatic wait_result();
    while (!DATA_OUT_ENABLE) begin
      @(negedge CLK);
    end
    @(negedge CLK);
    last_result = exp_q.pop_front();
    exp_head    = (exp_q.size() > 0) ? exp_q[0] : '0;
    in_flight   = 1'b0;
    sum_cmd     = 1'b0;
  endtask

  task automatic run_addsub(opcode_t op, data_t m, data_t a, data_t b);
    data_t expv;
    expv = (op == OP_SUB) ? expect_sub(a, b, m) : expect_add(a, b, m);
    issue(op, m, data_t'(1), a, b, expv);
    wait_result();
  endtask

  task automatic run_sum(data_t m, int len);
    data_t samples[MAX_LEN];
    data_t expv;
    int    i;
    expv = '0;
    for (i = 0; i < len; i++) begin
      samples[i] = $urandom % m;
      expv       = expect_add(expv, samples[i], m);
    end
    issue(OP_SUM, m, data_t'(len), '0, '0, expv);
    // Enabled junk ahead of the accumulate state is dropped
    DATA_IN        = $urandom;
    DATA_IN_ENABLE = 1'b1;
    @(negedge CLK);
    for (i = 0; i < len; i++) begin
      DATA_IN_ENABLE = 1'b0;
      last_en        = 1'b0;
      repeat ($urandom % (MAX_GAP + 1)) @(negedge CLK);
      DATA_IN        = samples[i];
      DATA_IN_ENABLE = 1'b1;
      last_en        = (i == len - 1);
      @(negedge CLK);
    end
    DATA_IN_ENABLE = 1'b0;
    last_en        = 1'b0;
    wait_result();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_idle : assert property (@(posedge CLK) disable iff (RST)
    !started |-> (!READY && !DATA_OUT_ENABLE))
    else abort_run("result strobe raised before any command was issued");

  a_value : assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> (DATA_OUT == exp_head))
    else abort_run($sformatf("ERR %0t DATA_OUT got %h expected %h",
                             $time, $sampled(DATA_OUT), $sampled(exp_head)));

  // Also covers the zero value out of reset
  a_hold : assert property (@(posedge CLK) disable iff (RST)
    !DATA_OUT_ENABLE |-> (DATA_OUT == last_result))
    else abort_run($sformatf("ERR %0t DATA_OUT got %h expected %h",
                             $time, $sampled(DATA_OUT), $sampled(last_result)));

  a_addsub_latency : assert property (@(posedge CLK) disable iff (RST)
    (START && (OPCODE != OP_SUM)) |->
      ##1 !DATA_OUT_ENABLE ##1 !DATA_OUT_ENABLE ##1 DATA_OUT_ENABLE)
    else abort_run("add or subtract result not exactly three edges after START");

  a_sum_latency : assert property (@(posedge CLK) disable iff (RST)
    last_en |-> ##1 !DATA_OUT_ENABLE ##1 DATA_OUT_ENABLE)
    else abort_run("summation result did not come one edge after the last sample");

  a_pulse : assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else abort_run("DATA_OUT_ENABLE held for more than one cycle");

  a_paired : assert property (@(posedge CLK) disable iff (RST)
    READY == DATA_OUT_ENABLE)
    else abort_run("READY and DATA_OUT_ENABLE were not pulsed together");

  // Extra strobe or a summation result ahead of its last sample
  a_expected : assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |-> (in_flight && (!sum_cmd || $past(last_en, 2))))
    else abort_run("result strobe with no command waiting for it");

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    n;
    data_t m;
    void'($urandom(9));
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    OPCODE         = OP_ADD;
    MODULO_IN      = '0;
    LENGTH_IN      = '0;
    DATA_A_IN      = '0;
    DATA_B_IN      = '0;
    DATA_IN        = '0;
    DATA_IN_ENABLE = 1'b0;
    exp_head       = '0;
    last_result    = '0;
    in_flight      = 1'b0;
    sum_cmd        = 1'b0;
    started        = 1'b0;
    last_en        = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    RST = 1'b0;
    // Quiet window after reset
    repeat (5) @(negedge CLK);
    // Carry out of 32 bits, borrow, exact modulus, length one and full length
    run_addsub(OP_ADD, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 32'hFFFF_FFFE);
    run_addsub(OP_SUB, 32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFE);
    run_addsub(OP_ADD, 32'd7, 32'd3, 32'd4);
    run_sum(32'd5, 1);
    run_sum(32'hFFFF_FFFF, MAX_LEN);
    // Random command mix with many back to back issues
    for (n = 0; n < NUM_CMDS; n++) begin
      repeat ($urandom % 3) @(negedge CLK);
      m = pick_modulus();
      case ($urandom % 3)
        0: run_addsub(OP_ADD, m, $urandom % m, $urandom % m);
        1: run_addsub(OP_SUB, m, $urandom % m, $urandom % m);
        default: run_sum(m, ($urandom % MAX_LEN) + 1);
      endcase
    end
    repeat (5) @(negedge CLK);
    $display("No errors");
    $finish;
  end

  initial begin
    #(TIMEOUT);
    abort_run("timeout, a command never completed");
  end

endmodule

// ==== files.f ====
design/ntm_arith_pkg.sv
design/ntm_cmd_pkg.sv
design/ntm_scalar_decode.sv
design/ntm_scalar_adder.sv
design/ntm_scalar_summation_function.sv
design/ntm_scalar_result.sv
design/ntm_scalar_unit.sv
bench/ntm_scalar_unit_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_scalar_unit

sources:
  - files:
      - design/ntm_arith_pkg.sv
      - design/ntm_cmd_pkg.sv
      - design/ntm_scalar_decode.sv
      - design/ntm_scalar_adder.sv
      - design/ntm_scalar_summation_function.sv
      - design/ntm_scalar_result.sv
      - design/ntm_scalar_unit.sv
  - target: test
    files:
      - bench/ntm_scalar_unit_tb.sv
